// ==== files.f ====
+incdir+.
bnnPkg.sv
xnorAccum.sv
sparseXnorLayer.sv
signThreshold.sv
layerSequencer.sv
bnnLayerTop.sv
bnnLayer_sva.sv
tb_bnnLayer.sv

// ==== run.sh ====
#!/bin/sh
# build and run the layer testbench with verilator.
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ns \
  -f files.f --top-module tb_bnnLayer -o simBnn
if [ $? -ne 0 ]; then
  echo "compile failed"
  exit 1
fi

./obj_dir/simBnn > "$LOG" 2>&1
simStatus=$?
cat "$LOG"

if grep -q "Checks failed" "$LOG"; then
  echo "FAIL"
  exit 1
fi
if [ $simStatus -ne 0 ]; then
  echo "FAIL: simulation exited with status $simStatus"
  exit 1
fi
echo "PASS"
exit 0

// ==== tb_bnnLayer.sv ====
`timescale 1ns/1ns
`include "bnn_defines.svh"

// directed testbench for the sparse binarized layer.
module tb_bnnLayer;
  import bnnPkg::*;

  localparam int maxWait = 4 * `N_IN;  // edges before giving up on done.

  // csr weights and thresholds, taken from the defines.
  localparam logic [`WNNZ-1:0]        wVals  = `W_VALS;
  localparam logic [8*`WNNZ-1:0]      wCol   = `W_COL;
  localparam logic [8*(`M_OUT+1)-1:0] wRow   = `W_ROW;
  localparam soumVecT                 thresh = `THRESH;

  logic    clk;
  logic    rst;
  logic    start;
  inVecT   inBits;
  logic    busy;
  logic    done;
  actVecT  actBits;
  soumVecT soums;

  logic [31:0] lcgState;

  bnnLayerTop dut0 (
    .clk    (clk),
    .rst    (rst),
    .start  (start),
    .inBits (inBits),
    .busy   (busy),
    .done   (done),
    .actBits(actBits),
    .soums  (soums)
  );

  always #50 clk = ~clk;  // 100 ns period.

  function automatic inVecT randVec();
    lcgState = lcgState * 32'd1664525 + 32'd1013904223;
    return lcgState[31 -: `N_IN];  // upper bits are the better ones.
  endfunction

  // row length from consecutive csr row starts.
  function automatic int rowLength(int r);
    return int'(wRow[(r+1)*8 +: 8]) - int'(wRow[r*8 +: 8]);
  endfunction

  // 2 * agree + MAX_LEN - len for every row.
  function automatic soumVecT refSoums(inVecT v);
    soumVecT s;
    int      first;
    int      len;
    int      col;
    int      agreeCnt;
    for (int r = 0; r < `M_OUT; r++) begin
      first    = int'(wRow[r*8 +: 8]);
      len      = rowLength(r);
      agreeCnt = 0;
      for (int i = 0; i < len; i++) begin
        col = int'(wCol[(first+i)*8 +: 8]);
        if (v[col] == wVals[first+i]) begin
          agreeCnt++;  // sign bit 1 wants a one.
        end
      end
      s[r] = soumT'(2 * agreeCnt + `MAX_LEN - len);
    end
    return s;
  endfunction

  function automatic actVecT refAct(soumVecT s);
    actVecT a;
    for (int r = 0; r < `M_OUT; r++) begin
      a[r] = (s[r] >= thresh[r]);
    end
    return a;
  endfunction

  // weighted rows sitting exactly on their threshold.
  function automatic int countTies(soumVecT s);
    int n;
    n = 0;
    for (int r = 0; r < `M_OUT; r++) begin
      if (rowLength(r) != 0 && s[r] == thresh[r]) begin
        n++;
      end
    end
    return n;
  endfunction

  task automatic reportFailure(string msg);
    $display("%s", msg);
    $display("Checks failed");
    $fatal(1, "stopping at the first error");
  endtask

  task automatic checkSoums(string name, soumVecT exp, soumVecT act);
    if (act !== exp) begin
      reportFailure($sformatf("Mismatch in %s: sums expected %h, actual %h", name, exp, act));
    end
  endtask

  task automatic checkAct(string name, actVecT exp, actVecT act);
    if (act !== exp) begin
      reportFailure($sformatf("Mismatch in %s: act expected %b, actual %b", name, exp, act));
    end
  endtask

  task automatic checkBit(string name, string what, logic exp, logic act);
    if (act !== exp) begin
      reportFailure($sformatf("Mismatch in %s: %s expected %b, actual %b",
                              name, what, exp, act));
    end
  endtask

  // returns right after edge 0.
  task automatic startRun(inVecT v);
    @(posedge clk);
    start  <= 1'b1;
    inBits <= v;
    @(posedge clk);
    start  <= 1'b0;
  endtask

  // entered at a rising edge, edgesSoFar edges after edge 0.
  task automatic waitDone(string name, int edgesSoFar);
    int   edges;
    logic seen;
    edges = edgesSoFar;
    seen  = 1'b0;
    while (!seen && edges <= maxWait) begin
      @(negedge clk);
      if (done) begin
        seen = 1'b1;
      end else begin
        checkBit(name, "busy during run", 1'b1, busy);
        @(posedge clk);
        edges++;
      end
    end
    if (!seen) begin
      reportFailure($sformatf("%s: done never came within %0d cycles", name, maxWait));
    end
    if (edges != `N_IN + 1) begin
      reportFailure($sformatf("Mismatch in %s: done latency expected %0d, actual %0d",
                              name, `N_IN + 1, edges));
    end
    checkBit(name, "busy at done", 1'b0, busy);
  endtask

  task automatic checkRun(string name, inVecT v);
    soumVecT exp;
    exp = refSoums(v);
    checkSoums(name, exp, soums);
    checkAct(name, refAct(exp), actBits);
  endtask

  task automatic testReset();
    @(negedge clk);
    checkBit("reset", "busy", 1'b0, busy);
    checkBit("reset", "done", 1'b0, done);
    checkAct("reset", '0, actBits);
    checkSoums("reset", '0, soums);
  endtask

  // the empty row reads MAX_LEN through the reference sums.
  task automatic testExtremes();
    inVecT v;
    for (int k = 0; k < 2; k++) begin
      v = (k == 0) ? '0 : '1;
      startRun(v);
      waitDone("extremes", 0);
      checkRun("extremes", v);
    end
  endtask

  task automatic testRandom();
    inVecT v;
    int    ties;
    ties = 0;
    for (int n = 0; n < 20; n++) begin
      v = randVec();
      startRun(v);
      waitDone("random", 0);
      checkRun("random", v);
      ties += countTies(refSoums(v));
    end
    $display("random vectors: %0d weighted rows on their threshold", ties);
    if (ties == 0) begin
      reportFailure("random: no weighted row landed on its threshold");
    end
  endtask

  task automatic testStartWhileBusy();
    inVecT v1;
    inVecT v2;
    v1 = randVec();
    v2 = ~v1;
    startRun(v1);
    @(posedge clk);
    start  <= 1'b1;
    inBits <= v2;
    @(posedge clk);   // second start sampled here, while busy.
    start  <= 1'b0;
    waitDone("start while busy", 2);
    checkRun("start while busy", v1);
    @(negedge clk);
    checkBit("start while busy", "busy after done", 1'b0, busy);
  endtask

  task automatic testInputChange();
    inVecT v;
    v = randVec();
    startRun(v);
    inBits <= ~v;      // after capture, must not matter.
    @(posedge clk);
    inBits <= randVec();
    waitDone("input change", 1);
    checkRun("input change", v);
  endtask

  // start stays high, so the second run is accepted in the done cycle.
  task automatic testBackToBack();
    inVecT v1;
    inVecT v2;
    v1 = randVec();
    v2 = randVec();
    if (v2 == v1) begin
      v2 = ~v1;
    end
    @(posedge clk);
    start  <= 1'b1;
    inBits <= v1;
    @(posedge clk);    // edge 0 of the first run.
    inBits <= v2;
    waitDone("back to back first", 0);
    checkRun("back to back first", v1);
    @(posedge clk);    // edge 0 of the second run.
    start <= 1'b0;
    waitDone("back to back second", 0);
    checkRun("back to back second", v2);
  endtask

  initial begin
    clk      = 1'b0;
    lcgState = 32'hb725_abb6;
    rst    <= 1'b1;
    start  <= 1'b0;
    inBits <= '0;
    repeat (4) @(posedge clk);
    rst <= 1'b0;

    testReset();
    testExtremes();
    testRandom();
    testStartWhileBusy();
    testInputChange();
    testBackToBack();

    $display("All checks passed");
    $finish;
  end

endmodule

// ==== bnnLayer_sva.sv ====
`timescale 1ns/1ns
`include "bnn_defines.svh"

// control protocol checks on the layer top.
module bnnLayerSva (
  input logic clk,
  input logic rst,
  input logic start,
  input logic busy,
  input logic done
);

  logic accepted;

  assign accepted = start && !busy;  // start seen while idle.

  // done lasts a single cycle.
  property donePulse;
    @(posedge clk) disable iff (rst) done |=> !done;
  endproperty

  // done is set at edge N_IN+1 and sampled one edge later.
  property doneAfterStart;
    @(posedge clk) disable iff (rst) accepted |-> ##(`N_IN + 2) done;
  endproperty

  property doneOnlyAfterStart;
    @(posedge clk) disable iff (rst) $rose(done) |-> $past(accepted, `N_IN + 2);
  endproperty

  property idleAtDone;
    @(posedge clk) disable iff (rst) $rose(done) |-> !busy;
  endproperty

  property quietInReset;
    @(posedge clk) rst |-> (!busy && !done);
  endproperty

  donePulseA: assert property (donePulse) else $error("done longer than one cycle");
  latencyA:   assert property (doneAfterStart) else $error("done missing after start");
  originA:    assert property (doneOnlyAfterStart) else $error("done without start");
  idleA:      assert property (idleAtDone) else $error("busy high at done");
  resetA:     assert property (quietInReset) else $error("busy or done high in reset");

endmodule

bind bnnLayerTop bnnLayerSva sva0 (
  .clk  (clk),
  .rst  (rst),
  .start(start),
  .busy (busy),
  .done (done)
);

// ==== bnnLayerTop.sv ====
`timescale 1ns/1ns

// one sparse binarized layer, sequencer, xnor layer and threshold stage.
// fixed latency of N_IN+1 cycles from start to done.
module bnnLayerTop (
  input  logic            clk,
  input  logic            rst,
  input  logic            start,
  input  bnnPkg::inVecT   inBits,
  output logic            busy,
  output logic            done,
  output bnnPkg::actVecT  actBits,
  output bnnPkg::soumVecT soums
);
  import bnnPkg::*;

  inVecT   dataReg;     // latched input vector.
  logic    clear;
  logic    enable;
  logic    load;
  soumVecT layerSoums;  // combinational sums from the layer.

  layerSequencer seq0 (
    .clk    (clk),
    .rst    (rst),
    .start  (start),
    .inBits (inBits),
    .dataReg(dataReg),
    .clear  (clear),
    .enable (enable),
    .load   (load),
    .busy   (busy),
    .done   (done)
  );

  sparseXnorLayer layer0 (
    .clk   (clk),
    .rst   (rst),
    .clear (clear),
    .enable(enable),
    .data  (dataReg),
    .soums (layerSoums)
  );

  signThreshold thresh0 (
    .clk     (clk),
    .rst     (rst),
    .load    (load),
    .soumsIn (layerSoums),
    .soumsOut(soums),
    .actBits (actBits)
  );

endmodule

// ==== layerSequencer.sv ====
`timescale 1ns/1ns
`include "bnn_defines.svh"

// start pulse to capture, clear, N_IN enable cycles, load and done.
module layerSequencer (
  input  logic          clk,
  input  logic          rst,
  input  logic          start,
  input  bnnPkg::inVecT inBits,
  output bnnPkg::inVecT dataReg,
  output logic          clear,
  output logic          enable,
  output logic          load,
  output logic          busy,
  output logic          done
);
  import bnnPkg::*;

  typedef enum logic [1:0] {
    stIdle,
    stRun,
    stLoad
  } stateT;

  stateT state;
  cntT   stepCnt;   // enabled cycles so far.
  logic  capture;   // accepted start.
  logic  lastStep;

  assign capture  = start && (state == stIdle);  // ignored while busy.
  assign clear    = capture;
  assign lastStep = (stepCnt == cntT'(`N_IN - 1));

  assign enable = (state == stRun);
  assign load   = (state == stLoad);
  assign busy   = (state != stIdle);

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state   <= stIdle;
      stepCnt <= '0;
      done    <= 1'b0;
    end else begin
      done <= 1'b0;
      case (state)
        stIdle: begin
          if (capture) begin
            state   <= stRun;
            stepCnt <= '0;
          end
        end
        stRun: begin
          if (lastStep) begin
            state <= stLoad;           // sums valid after this edge.
          end else begin
            stepCnt <= stepCnt + cntT'(1);
          end
        end
        stLoad: begin
          state <= stIdle;
          done  <= 1'b1;               // output registers load at this edge.
        end
        default: state <= stIdle;
      endcase
    end
  end

  // input vector only matters at the accepting edge.
  always_ff @(posedge clk) begin
    if (capture) begin
      dataReg <= inBits;
    end
  end

endmodule

// ==== signThreshold.sv ====
`timescale 1ns/1ns
`include "bnn_defines.svh"

// sign activation against per-row thresholds, one register stage.
module signThreshold (
  input  logic            clk,
  input  logic            rst,
  input  logic            load,
  input  bnnPkg::soumVecT soumsIn,
  output bnnPkg::soumVecT soumsOut,
  output bnnPkg::actVecT  actBits
);
  import bnnPkg::*;

  localparam soumVecT thresh = `THRESH;

  actVecT actNext;

  // a sum equal to its threshold fires.
  always_comb begin
    for (int r = 0; r < `M_OUT; r++) begin
      actNext[r] = (soumsIn[r] >= thresh[r]);
    end
  end

  // results hold until the next load.
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      soumsOut <= '0;
      actBits  <= '0;
    end else if (load) begin
      soumsOut <= soumsIn;
      actBits  <= actNext;
    end
  end

endmodule

// ==== sparseXnorLayer.sv ====
`timescale 1ns/1ns
`include "bnn_defines.svh"

// fully connected binarized layer with sparse ternary weights.
// each row sees one input position per enabled cycle.
module sparseXnorLayer (
  input  logic            clk,
  input  logic            rst,
  input  logic            clear,
  input  logic            enable,
  input  bnnPkg::inVecT   data,
  output bnnPkg::soumVecT soums
);
  import bnnPkg::*;

  // csr tables as flat byte arrays.
  localparam logic [`WNNZ-1:0]         wVals   = `W_VALS;
  localparam logic [8*`WNNZ-1:0]       wCol    = `W_COL;
  localparam logic [8*(`M_OUT+1)-1:0]  wRow    = `W_ROW;
  localparam logic [8*`M_OUT-1:0]      rowLens = `ROW_LEN;

  cntT  cnt;  // shared bit position for all rows.
  logic off;  // last position reached.

  assign off = (cnt == cntT'(`N_IN - 1));

  // counter holds at the last position until the next clear.
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      cnt <= '0;
    end else if (clear) begin
      cnt <= '0;
    end else if (enable && !off) begin
      cnt <= cnt + cntT'(1);
    end
  end

  for (genvar r = 0; r < `M_OUT; r++) begin : gRow
    localparam int len   = int'(rowLens[r*8 +: 8]);
    localparam int first = int'(wRow[r*8 +: 8]);

    if (len != 0) begin : gAcc
      // correction term, MAX_LEN is never below a row length.
      localparam soumT corr = soumT'(`MAX_LEN - len);

      inVecT agree;  // agreement bit per row position, padded with zeros.
      accT   acc;

      for (genvar i = 0; i < `N_IN; i++) begin : gSel
        if (i < len) begin : gTap
          localparam int col = int'(wCol[(first+i)*8 +: 8]);

          // +1 weight agrees with a one, -1 weight with a zero.
          if (wVals[first+i]) begin : gPos
            assign agree[i] = data[col];
          end else begin : gNeg
            assign agree[i] = ~data[col];
          end
        end else begin : gPad
          assign agree[i] = 1'b0;  // beyond the row.
        end
      end

      xnorAccum #(
        .rowLen(len)
      ) accum (
        .clk   (clk),
        .rst   (rst),
        .clear (clear),
        .enable(enable),
        .bitIn (agree[cnt]),
        .cnt   (cnt),
        .acc   (acc)
      );

      // 2*agree + MAX_LEN - len.
      assign soums[r] = soumT'({acc, 1'b0}) + corr;
    end else begin : gEmpty
      // no weights, the sum sits at the common offset.
      assign soums[r] = soumT'(`MAX_LEN);
    end
  end

endmodule

// ==== xnorAccum.sv ====
`timescale 1ns/1ns

// bit-serial popcount of agreeing inputs for one weight row.
// the layer presents one agreement bit per enabled cycle, selected by cnt.
module xnorAccum #(
  parameter int rowLen = 1  // non-zero weights in this row.
) (
  input  logic        clk,
  input  logic        rst,
  input  logic        clear,
  input  logic        enable,
  input  logic        bitIn,
  input  bnnPkg::cntT cnt,
  output bnnPkg::accT acc
);
  import bnnPkg::*;

  logic inRow;  // position still inside the row.
  logic addOne;

  // short rows stop counting on their own once cnt passes the length.
  assign inRow  = int'(cnt) < rowLen;
  assign addOne = enable && inRow && bitIn;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      acc <= '0;
    end else if (clear) begin
      acc <= '0;              // new inference.
    end else if (addOne) begin
      acc <= acc + accT'(1);
    end
  end

endmodule

// ==== bnnPkg.sv ====
`include "bnn_defines.svh"

package bnnPkg;

  // input bits and output activations.
  typedef logic [`N_IN-1:0]  inVecT;
  typedef logic [`M_OUT-1:0] actVecT;

  // bit position within the input vector.
  typedef logic [$clog2(`N_IN)-1:0] cntT;

  // raw agree count of one row.
  typedef logic [`SUM_W-1:0] accT;

  // corrected sum, offset by MAX_LEN so every row shares one scale.
  typedef logic [`SOUM_W-1:0] soumT;

  // one corrected sum per output row, row 0 in the low bits.
  typedef soumT [`M_OUT-1:0] soumVecT;

endpackage

// ==== bnn_defines.svh ====
`ifndef BNN_DEFINES_SVH
`define BNN_DEFINES_SVH

// layer shape.
`define N_IN    8
`define M_OUT   4
`define MAX_LEN 5     // longest row, common offset of all sums.

// accumulator and corrected sum widths.
`define SUM_W  3      // agree count up to MAX_LEN.
`define SOUM_W (`SUM_W + 2)

// sparse weights, CSR form, index 0 in the low bits.
// row 0 cols 0 2 3 5 7, row 1 cols 1 4 6, row 2 empty, row 3 cols 0 1 3 6.
`define WNNZ    12
`define W_VALS  12'b1010_011_01101   // sign per non-zero, 1 is +1.
`define W_COL   96'h06_03_01_00_06_04_01_07_05_03_02_00
`define W_ROW   40'h0C_08_08_05_00   // row starts, last entry is WNNZ.
`define ROW_LEN 32'h04_00_03_05

// activation thresholds, row 0 rightmost.
// row 0 sums 0..10, row 1 2..8, row 2 fixed 5, row 3 1..9.
`define THRESH {5'd5, 5'd5, 5'd4, 5'd6}

`endif
